// File: hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

  // ============================================================
  // widths and sizes
  // ============================================================
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int memAddrWidth = 7;   // data memory word address
  localparam int memDepth     = 128; // data memory words

  // ============================================================
  // opcode field, instr[31:26]
  // ============================================================
  localparam logic [5:0] opRtype = 6'b000000;
  localparam logic [5:0] opAddi  = 6'b001000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opJal   = 6'b000011;

  // funct field, instr[5:0], R-type only
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;
  localparam logic [5:0] fnSll = 6'b000000;
  localparam logic [5:0] fnSrl = 6'b000010;
  localparam logic [5:0] fnJr  = 6'b001000;

  // alu operation select
  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluAnd = 4'd2,
    aluOr  = 4'd3,
    aluSlt = 4'd4, // signed compare
    aluSll = 4'd5,
    aluSrl = 4'd6
  } aluOp_t;

  // ============================================================
  // decoded controls, 15 bits
  // ============================================================
  typedef struct packed {
    logic   regDst;    // dest is rd, else rt
    logic   aluSrcImm; // alu b from immediate
    logic   aluShamt;  // alu a from shamt field
    logic   memToReg;  // write back load data
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   branch;    // beq
    logic   jump;      // j, jal
    logic   link;      // jal, writes r31
    logic   jumpReg;   // jr
    aluOp_t aluOp;
  } ctrl_t;

  // data memory request, sram style, controls active low
  typedef struct packed {
    logic                    cen;
    logic                    wen;
    logic                    oen;
    logic [memAddrWidth-1:0] addr;  // word address
    logic [dataWidth-1:0]    wdata;
  } dmemReq_t;

  // register write-back as committed at the next edge
  typedef struct packed {
    logic                    en;
    logic [regAddrWidth-1:0] addr;
    logic [dataWidth-1:0]    data;
  } wbInfo_t;

endpackage

`default_nettype wire

// File: hdl/controlUnit.sv
`default_nettype none

module controlUnit (
  input  wire [mipsPkg::dataWidth-1:0] instr,
  output mipsPkg::ctrl_t               ctrl
);
  import mipsPkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  // ============================================================
  // main decoder
  // ============================================================
  always_comb begin
    ctrl       = '0;     // unknown op: no reg write, no mem access
    ctrl.aluOp = aluAdd;
    unique case (opcode)
      opRtype: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct)       // funct picks the alu op
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr:  ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          fnSll: begin
            ctrl.aluOp    = aluSll;
            ctrl.aluShamt = 1'b1; // shift count from instr[10:6]
          end
          fnSrl: begin
            ctrl.aluOp    = aluSrl;
            ctrl.aluShamt = 1'b1;
          end
          fnJr: begin
            ctrl.jumpReg  = 1'b1;
            ctrl.regWrite = 1'b0; // jr writes nothing
          end
          default: ctrl.regWrite = 1'b0; // unknown funct, no effect
        endcase
      end
      opAddi: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
      end
      opLw: begin
        ctrl.aluSrcImm = 1'b1; // base + offset
        ctrl.memRead   = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
      end
      opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub; // zero flag means equal
      end
      opJ:   ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1; // r31 <= pc + 4
        ctrl.regWrite = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/aluUnit.sv
`default_nettype none

module aluUnit (
  input  wire [mipsPkg::dataWidth-1:0] a,
  input  wire [mipsPkg::dataWidth-1:0] b,
  input  wire mipsPkg::aluOp_t         aluOp,
  output logic [mipsPkg::dataWidth-1:0] result,
  output logic                          zero
);
  import mipsPkg::*;

  logic [4:0] shiftAmt;   // shifts use only a[4:0]
  logic       lessSigned;

  assign shiftAmt   = a[4:0];
  assign lessSigned = $signed(a) < $signed(b);

  // ============================================================
  // operation select
  // ============================================================
  always_comb begin
    unique case (aluOp)
      aluAdd: result = a + b;  // addi, lw, sw address too
      aluSub: result = a - b;  // also beq compare
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      aluSlt: begin
        // signed compare, bit 0 only
        result = {{(dataWidth-1){1'b0}}, lessSigned};
      end
      aluSll: result = b << shiftAmt; // b is rt, a is shamt
      aluSrl: result = b >> shiftAmt; // logical, zero fill
      default: result = '0;
    endcase
  end

  // only beq looks at this
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`default_nettype none

module regFile (
  input  wire                              clk,
  input  wire                              rst,
  input  wire [mipsPkg::regAddrWidth-1:0]  rdAddrA,
  input  wire [mipsPkg::regAddrWidth-1:0]  rdAddrB,
  input  wire                              wrEn,
  input  wire [mipsPkg::regAddrWidth-1:0]  wrAddr,
  input  wire [mipsPkg::dataWidth-1:0]     wrData,
  output logic [mipsPkg::dataWidth-1:0]    rdDataA,
  output logic [mipsPkg::dataWidth-1:0]    rdDataB
);
  import mipsPkg::*;

  // r1..r31, r0 has no storage
  logic [dataWidth-1:0] regs [1:31];

  logic doWrite;

  // nothing commits while reset is held
  assign doWrite = wrEn && rst && (wrAddr != '0);

  always_ff @(posedge clk) begin
    if (doWrite) begin
      regs[wrAddr] <= wrData;
    end
  end

  // ============================================================
  // read ports, combinational
  // ============================================================
  // new value shows up the cycle after the write edge
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// File: hdl/pcUnit.sv
`default_nettype none

module pcUnit (
  input  wire                            clk,
  input  wire                            rst,
  input  wire mipsPkg::ctrl_t            ctrl,
  input  wire                            zero,
  input  wire [mipsPkg::dataWidth-1:0]   immExt,
  input  wire [25:0]                     jumpField,
  input  wire [mipsPkg::dataWidth-1:0]   rsData,
  output logic [mipsPkg::dataWidth-1:0]  pc,
  output logic [mipsPkg::dataWidth-1:0]  pcPlus4
);
  import mipsPkg::*;

  logic [dataWidth-1:0] pcNext;
  logic [dataWidth-1:0] jumpTarget;
  logic [dataWidth-1:0] branchTarget;
  logic                 branchTaken;

  assign pcPlus4 = pc + 32'd4; // no delay slot

  // pseudo-direct, top nibble from pc + 4
  assign jumpTarget = {pcPlus4[31:28], jumpField, 2'b00};

  // word offset relative to the next instruction
  assign branchTarget = pcPlus4 + {immExt[dataWidth-3:0], 2'b00};

  assign branchTaken = ctrl.branch & zero;

  // ============================================================
  // next pc, jr first, then j/jal, then taken beq
  // ============================================================
  always_comb begin
    if (ctrl.jumpReg) begin
      pcNext = rsData;
    end else if (ctrl.jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;      // sequential
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;              // first fetch at 0
    end else begin
      pc <= pcNext;
    end
  end

endmodule

`default_nettype wire

// File: hdl/mipsCore.sv
`default_nettype none

module mipsCore (
  input  wire                            clk,
  input  wire                            rst,
  output logic [mipsPkg::dataWidth-1:0]  instrAddr,
  input  wire [mipsPkg::dataWidth-1:0]   instr,
  output mipsPkg::dmemReq_t              dmem,
  input  wire [mipsPkg::dataWidth-1:0]   dmemRdata,
  output mipsPkg::wbInfo_t               wb
);
  import mipsPkg::*;

  ctrl_t                   ctrl;
  logic [regAddrWidth-1:0] rs, rt, rd;
  logic [4:0]              shamt;
  logic [15:0]             imm;
  logic [25:0]             jumpField;
  logic [dataWidth-1:0]    immExt;
  logic [dataWidth-1:0]    rsData, rtData;
  logic [dataWidth-1:0]    aluA, aluB, aluResult;
  logic                    aluZero;
  logic [dataWidth-1:0]    pc, pcPlus4;
  logic [regAddrWidth-1:0] wrAddr;
  logic [dataWidth-1:0]    wrData;
  logic                    wrEn;

  // ============================================================
  // field extraction
  // ============================================================
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign shamt     = instr[10:6];
  assign imm       = instr[15:0];
  assign jumpField = instr[25:0];
  assign immExt    = {{(dataWidth-16){imm[15]}}, imm}; // sign extend

  controlUnit i_control (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // link beats rd, rd beats rt
  assign wrAddr = ctrl.link   ? 5'd31 :
                  ctrl.regDst ? rd    : rt;
  assign wrEn   = ctrl.regWrite & (wrAddr != '0); // r0 never written

  regFile i_regFile (
    .clk     (clk),
    .rst     (rst),
    .rdAddrA (rs),
    .rdAddrB (rt),
    .wrEn    (wrEn),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .rdDataA (rsData),
    .rdDataB (rtData)
  );

  // operand muxes
  assign aluA = ctrl.aluShamt  ? {{(dataWidth-5){1'b0}}, shamt} : rsData;
  assign aluB = ctrl.aluSrcImm ? immExt : rtData;

  aluUnit i_alu (
    .a      (aluA),
    .b      (aluB),
    .aluOp  (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  pcUnit i_pc (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .zero      (aluZero),
    .immExt    (immExt),
    .jumpField (jumpField),
    .rsData    (rsData),
    .pc        (pc),
    .pcPlus4   (pcPlus4)
  );

  assign instrAddr = pc;

  // ============================================================
  // write-back select and ports
  // ============================================================
  assign wrData = ctrl.link     ? pcPlus4   :  // jal return address
                  ctrl.memToReg ? dmemRdata :
                                  aluResult;

  always_comb begin
    dmem.cen   = ~(ctrl.memRead | ctrl.memWrite); // active low
    dmem.wen   = ~ctrl.memWrite;
    dmem.oen   = ~ctrl.memRead;
    dmem.addr  = aluResult[memAddrWidth+1:2];     // byte to word
    dmem.wdata = rtData;                          // sw stores rt
  end

  always_comb begin
    wb.en   = wrEn;
    wb.addr = wrAddr;
    wb.data = wrData;
  end

endmodule

`default_nettype wire

// File: testbench/mipsMemModel.sv
`default_nettype none

// ============================================================
// instruction ROM, combinational read, contents set by the testbench
// ============================================================
module instrRom (
  input  wire [31:0] addr,  // byte address
  output logic [31:0] data
);
  logic [31:0] mem [0:63];

  assign data = mem[addr[7:2]]; // word index, same cycle
endmodule

// ============================================================
// data SRAM, 128 words, active-low controls
// ============================================================
module dataSram (
  input  wire                          clk,
  input  wire mipsPkg::dmemReq_t       req,
  output logic [mipsPkg::dataWidth-1:0] rdata
);
  import mipsPkg::*;

  logic [dataWidth-1:0] mem [0:memDepth-1];

  // every word gets its own value, so a wrong address shows up
  initial begin
    for (int k = 0; k < memDepth; k++) begin
      mem[k] = 32'hc0de_0000 ^ (32'(k) * 32'h0001_0203);
    end
  end

  always @(posedge clk) begin
    if (!req.cen && !req.wen) begin
      mem[req.addr] <= req.wdata; // write at the edge
    end
  end

  // read word appears in the same cycle
  assign rdata = (!req.cen && !req.oen && req.wen) ? mem[req.addr] : '0;
endmodule

`default_nettype wire

// File: testbench/mipsCore_assert.sv
`default_nettype none

module mipsCoreAssert (
  input wire                          clk,
  input wire                          rst,
  input wire mipsPkg::dmemReq_t       dmem,
  input wire [mipsPkg::dataWidth-1:0] pc
);
  import mipsPkg::*;

  logic firstCycle;  // set until the first edge after release
  int   assertFails; // bumped by every failing property

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      firstCycle <= 1'b1;
    end else begin
      firstCycle <= 1'b0;
    end
  end

  // ============================================================
  // memory control legality
  // ============================================================
  wenNeedsCen: assert property (@(posedge clk) disable iff (!rst)
    !dmem.wen |-> !dmem.cen)
    else begin
      assertFails++;
      $error("dmem write enable low while chip enable is high");
    end

  noReadWrite: assert property (@(posedge clk) disable iff (!rst)
    !(!dmem.oen && !dmem.wen))
    else begin
      assertFails++;
      $error("dmem output enable and write enable both low");
    end

  // fetch side
  pcAligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
    else begin
      assertFails++;
      $error("pc is not word aligned");
    end

  pcAfterReset: assert property (@(posedge clk) firstCycle |-> pc == '0)
    else begin
      assertFails++;
      $error("pc is not zero in the first cycle after reset");
    end

endmodule

bind mipsCore mipsCoreAssert i_assert (
  .clk  (clk),
  .rst  (rst),
  .dmem (dmem),
  .pc   (pc)
);

`default_nettype wire

// File: testbench/mipsCoreTb.sv
`default_nettype none

module mipsCoreTb;
  import mipsPkg::*;

  localparam int clkPeriod = 40;
  localparam int numSteps  = 22; // executed instructions
  localparam int romDepth  = 64;

  // one executed instruction and what it should do
  typedef struct packed {
    logic [31:0]             pc;
    logic [31:0]             instr;
    logic                    wbEn;
    logic [4:0]              wbAddr;
    logic [31:0]             wbData;
    logic                    memWr;   // store expected
    logic [memAddrWidth-1:0] memAddr;
    logic [31:0]             memData;
  } stepRow_t;

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  logic [31:0] instr;
  dmemReq_t    dmem;
  logic [31:0] dmemRdata;
  wbInfo_t     wb;

  stepRow_t steps [numSteps];
  int       stepCount;
  int       errors;
  int       checked;
  int       assertFails;

  mipsCore i_dut (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dmem      (dmem),
    .dmemRdata (dmemRdata),
    .wb        (wb)
  );

  instrRom i_rom (.addr(instrAddr), .data(instr));
  dataSram i_dmem (.clk(clk), .req(dmem), .rdata(dmemRdata));

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  // ============================================================
  // instruction encoding and table building
  // ============================================================
  function automatic logic [31:0] rFormat(input logic [4:0] rs, rt, rd, shamt,
                                          input logic [5:0] funct);
    return {opRtype, rs, rt, rd, shamt, funct};
  endfunction

  function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jFormat(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic addStep(input logic [31:0] pc, instrWord, input logic wbEn,
                         input logic [4:0] wbAddr, input logic [31:0] wbData);
    steps[stepCount] = {pc, instrWord, wbEn, wbAddr, wbData, 1'b0, 7'd0, 32'd0};
    stepCount++;
  endtask

  task automatic addStore(input logic [31:0] pc, instrWord,
                          input logic [memAddrWidth-1:0] memAddr, input logic [31:0] memData);
    steps[stepCount] = {pc, instrWord, 1'b0, 5'd0, 32'd0, 1'b1, memAddr, memData};
    stepCount++;
  endtask

  task automatic buildTable();
    stepCount = 0;
    addStep(32'h00, iFormat(opAddi, 5'd0, 5'd1, 16'd5), 1'b1, 5'd1, 32'd5);
    addStep(32'h04, iFormat(opAddi, 5'd0, 5'd2, 16'hfffd), 1'b1, 5'd2, 32'hffff_fffd);
    addStep(32'h08, rFormat(5'd1, 5'd2, 5'd3, 5'd0, fnAdd), 1'b1, 5'd3, 32'd2);
    addStep(32'h0c, rFormat(5'd1, 5'd2, 5'd4, 5'd0, fnSub), 1'b1, 5'd4, 32'd8);
    addStep(32'h10, rFormat(5'd1, 5'd2, 5'd5, 5'd0, fnAnd), 1'b1, 5'd5, 32'd5);
    addStep(32'h14, rFormat(5'd1, 5'd2, 5'd6, 5'd0, fnOr), 1'b1, 5'd6, 32'hffff_fffd);
    addStep(32'h18, rFormat(5'd2, 5'd1, 5'd7, 5'd0, fnSlt), 1'b1, 5'd7, 32'd1); // -3 < 5
    addStep(32'h1c, rFormat(5'd1, 5'd2, 5'd8, 5'd0, fnSlt), 1'b1, 5'd8, 32'd0);
    addStep(32'h20, rFormat(5'd1, 5'd1, 5'd0, 5'd0, fnAdd), 1'b0, 5'd0, 32'd0); // r0 dest
    addStep(32'h24, rFormat(5'd0, 5'd1, 5'd9, 5'd4, fnSll), 1'b1, 5'd9, 32'h50);
    addStep(32'h28, rFormat(5'd0, 5'd2, 5'd10, 5'd8, fnSrl), 1'b1, 5'd10, 32'h00ff_ffff);
    addStep(32'h2c, iFormat(opAddi, 5'd0, 5'd11, 16'h40), 1'b1, 5'd11, 32'h40);
    addStore(32'h30, iFormat(opSw, 5'd11, 5'd9, 16'd8), 7'h12, 32'h50); // byte 0x48
    addStep(32'h34, iFormat(opLw, 5'd11, 5'd12, 16'd8), 1'b1, 5'd12, 32'h50);
    addStep(32'h38, iFormat(opBeq, 5'd12, 5'd9, 16'd2), 1'b0, 5'd0, 32'd0);  // taken
    addStep(32'h44, iFormat(opBeq, 5'd1, 5'd2, 16'd5), 1'b0, 5'd0, 32'd0);   // falls through
    addStep(32'h48, jFormat(opJal, 26'h18), 1'b1, 5'd31, 32'h4c);
    addStep(32'h60, iFormat(opAddi, 5'd0, 5'd13, 16'd7), 1'b1, 5'd13, 32'd7);
    addStep(32'h64, rFormat(5'd31, 5'd0, 5'd0, 5'd0, fnJr), 1'b0, 5'd0, 32'd0);
    addStep(32'h4c, jFormat(opJ, 26'h1c), 1'b0, 5'd0, 32'd0);
    addStep(32'h70, iFormat(opAddi, 5'd13, 5'd14, 16'd1), 1'b1, 5'd14, 32'd8);
    addStep(32'h74, rFormat(5'd14, 5'd12, 5'd15, 5'd0, fnAdd), 1'b1, 5'd15, 32'h58);
  endtask

  // unused words hold addi r0, r0, index, which changes nothing
  task automatic loadRom();
    for (int k = 0; k < romDepth; k++) begin
      i_rom.mem[k] = iFormat(opAddi, 5'd0, 5'd0, 16'(k));
    end
    for (int k = 0; k < numSteps; k++) begin
      i_rom.mem[steps[k].pc[7:2]] = steps[k].instr;
    end
  endtask

  // ============================================================
  // checking
  // ============================================================
  task automatic reportMismatch(input string what, input int idx,
                                input logic [31:0] got, input logic [31:0] exp);
    $display("FAILED %0t: step %0d %s got %h expected %h", $time, idx, what, got, exp);
    errors++;
  endtask

  task automatic checkStep(input int idx);
    stepRow_t row;
    row = steps[idx];
    checked++;
    assert (instrAddr == row.pc) else reportMismatch("fetch address", idx, instrAddr, row.pc);
    assert (instr == row.instr) else reportMismatch("instruction", idx, instr, row.instr);
    assert (wb.en == row.wbEn)
      else reportMismatch("write-back enable", idx, 32'(wb.en), 32'(row.wbEn));
    if (row.wbEn) begin
      assert (wb.addr == row.wbAddr)
        else reportMismatch("write-back register", idx, 32'(wb.addr), 32'(row.wbAddr));
      assert (wb.data == row.wbData)
        else reportMismatch("write-back data", idx, wb.data, row.wbData);
    end
    if (row.memWr) begin
      assert (!dmem.cen && !dmem.wen && dmem.oen)  // cen, wen, oen as 0 0 1
        else reportMismatch("store controls", idx, 32'({dmem.cen, dmem.wen, dmem.oen}), 32'd1);
      assert (dmem.addr == row.memAddr)
        else reportMismatch("store address", idx, 32'(dmem.addr), 32'(row.memAddr));
      assert (dmem.wdata == row.memData)
        else reportMismatch("store data", idx, dmem.wdata, row.memData);
    end else begin
      assert (dmem.wen) else reportMismatch("write enable", idx, 32'(dmem.wen), 32'd1);
    end
  endtask

  // ============================================================
  // main sequence and watchdog
  // ============================================================
  initial begin
    rst     = 1'b0;
    errors  = 0;
    checked = 0;
    buildTable();
    loadRom();
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b1;
    for (int i = 0; i < numSteps; i++) begin
      @(negedge clk);
      #(clkPeriod / 2 - 4); // just before the commit edge
      checkStep(i);
      @(posedge clk);
    end
    @(negedge clk); // properties of the last edge have reported
    assertFails = i_dut.i_assert.assertFails;
    $display("steps checked: %0d, errors: %0d, assertion failures: %0d",
             checked, errors, assertFails);
    if (errors == 0 && assertFails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((numSteps + 10) * clkPeriod);
    $display("watchdog expired: the program did not complete in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hdl/mipsPkg.sv
hdl/controlUnit.sv
hdl/aluUnit.sv
hdl/regFile.sv
hdl/pcUnit.sv
hdl/mipsCore.sv
testbench/mipsMemModel.sv
testbench/mipsCore_assert.sv
testbench/mipsCoreTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --assert --top-module mipsCoreTb -Mdir "$buildDir" -f filelist.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$buildDir/VmipsCoreTb" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$logFile"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation passed"
exit 0
